/* design/isa_pkg.sv */
package isa_pkg;

    localparam int NUM_REGS = 16;

    typedef logic [15:0] word_t;
    typedef logic [3:0]  reg_addr_t;

    // PC step between instructions, in bytes
    localparam word_t INSTR_BYTES = 16'd2;

    // The register ALU ops share their low 3 bits with alu_op_e
    typedef enum logic [3:0] {
        ADD  = 4'd0,
        SUB  = 4'd1,
        AND  = 4'd2,
        OR   = 4'd3,
        XOR  = 4'd4,
        SLL  = 4'd5,
        SRL  = 4'd6,
        SLT  = 4'd7,
        LI   = 4'd8,
        ADDI = 4'd9,
        BEQ  = 4'd10,
        BNE  = 4'd11,
        JAL  = 4'd12,
        OUT  = 4'd13,
        HALT = 4'd14
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLL = 3'd5,
        ALU_SRL = 3'd6,
        ALU_SLT = 3'd7
    } alu_op_e;

    // BEQ/BNE compare rd with rs1 and take rs2 as a signed offset
    typedef struct packed {
        opcode_e   opcode;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
    } r_fmt_t;

    typedef struct packed {
        opcode_e           opcode;
        reg_addr_t         rd;
        logic signed [7:0] imm;
    } i_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
    } instr_u;

endpackage

/* design/core_pkg.sv */
package core_pkg;

    import isa_pkg::*;

    typedef logic [15:0] pc_t;

    typedef enum logic [2:0] {
        LOAD,
        FETCH,
        DECODE,
        EXECUTE,
        RETIRE,
        HALTED
    } stage_e;

    typedef enum logic [1:0] {
        BR_NONE,
        BR_EQ,
        BR_NE,
        BR_JAL
    } br_kind_e;

    typedef struct packed {
        alu_op_e   alu_op;
        logic      use_imm;
        logic      load_imm;
        logic      reg_write;
        reg_addr_t rd;
        br_kind_e  branch;
        logic      out_en;
        logic      halt;
        word_t     imm;
    } ctrl_t;

    typedef struct packed {
        logic [7:0] addr;
        word_t      word;
        logic       last;
    } load_t;

    typedef struct packed {
        logic      en;
        reg_addr_t rd;
        word_t     data;
    } reg_wr_t;

    typedef struct packed {
        pc_t  next_pc;
        logic halt;
    } redirect_t;

endpackage

/* design/fetch_unit.sv */
`timescale 1ns/100ps

module fetch_unit
    import isa_pkg::*;
    import core_pkg::*;
#(
    parameter int PROG_ADDR_BITS = 8
) (
    input  logic      clk,
    input  logic      reset_n,
    input  logic      load_valid,
    output logic      load_ready,
    input  load_t     load_data,
    input  logic      commit,
    input  redirect_t redirect,
    output instr_u    instr,
    output pc_t       pc,
    output logic      decode_en,
    output logic      exec_en,
    output logic      retire_en,
    output logic      halted
);

    localparam int PROG_WORDS = 2 ** PROG_ADDR_BITS;

    stage_e stage;
    word_t  prog_mem [PROG_WORDS];

    logic                      load_fire;
    logic [PROG_ADDR_BITS-1:0] wr_addr;
    logic [PROG_ADDR_BITS-1:0] rd_addr;

    assign load_ready = (stage == LOAD);
    assign load_fire  = load_valid && load_ready;
    assign wr_addr    = PROG_ADDR_BITS'(load_data.addr);
    // Byte PC to word index
    assign rd_addr    = pc[PROG_ADDR_BITS:1];

    assign decode_en = (stage == DECODE);
    assign exec_en   = (stage == EXECUTE);
    // Stays up while retire waits on the output stream
    assign retire_en = (stage == RETIRE);
    assign halted    = (stage == HALTED);

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            stage <= LOAD;
            pc    <= '0;
        end else begin
            case (stage)
                LOAD: begin
                    if (load_fire && load_data.last) begin
                        stage <= FETCH;
                        pc    <= '0;
                    end
                end
                FETCH: begin
                    stage <= DECODE;
                end
                DECODE: begin
                    stage <= EXECUTE;
                end
                EXECUTE: begin
                    stage <= RETIRE;
                end
                RETIRE: begin
                    if (commit) begin
                        pc    <= redirect.next_pc;
                        stage <= redirect.halt ? HALTED : FETCH;
                    end
                end
                default: begin
                    stage <= HALTED;
                end
            endcase
        end
    end

    // Program memory, written by the load port, read in FETCH
    always_ff @(posedge clk) begin
        if (load_fire) begin
            prog_mem[wr_addr] <= load_data.word;
        end
        if (stage == FETCH) begin
            instr <= prog_mem[rd_addr];
        end
    end

endmodule

/* design/decode_stage.sv */
`timescale 1ns/100ps

module decode_stage
    import isa_pkg::*;
    import core_pkg::*;
(
    input  logic    clk,
    input  logic    reset_n,
    input  logic    decode_en,
    input  instr_u  instr,
    input  pc_t     pc,
    input  reg_wr_t reg_wr,
    output ctrl_t   ctrl,
    output word_t   rs_a,
    output word_t   rs_b,
    output pc_t     pc_out
);

    word_t     regs [NUM_REGS];
    ctrl_t     ctrl_d;
    opcode_e   opcode;
    reg_addr_t addr_a;
    reg_addr_t addr_b;
    logic      is_r_alu;
    logic      is_branch;
    word_t     imm_i;
    word_t     imm_br;

    assign opcode    = instr.r_fmt.opcode;
    assign is_r_alu  = (opcode inside {ADD, SUB, AND, OR, XOR, SLL, SRL, SLT});
    assign is_branch = (opcode inside {BEQ, BNE});
    assign imm_i     = {{8{instr.i_fmt.imm[7]}}, instr.i_fmt.imm};
    assign imm_br    = {{12{instr.r_fmt.rs2[3]}}, instr.r_fmt.rs2};

    // Everything outside the register ALU ops reads rd on port a
    assign addr_a = is_r_alu ? instr.r_fmt.rs1 : instr.i_fmt.rd;
    assign addr_b = is_branch ? instr.r_fmt.rs1 : instr.r_fmt.rs2;

    always_comb begin
        ctrl_d = '0;
        case (opcode)
            ADD, SUB, AND, OR, XOR, SLL, SRL, SLT: begin
                ctrl_d.alu_op    = alu_op_e'(opcode[2:0]);
                ctrl_d.reg_write = 1'b1;
                ctrl_d.rd        = instr.r_fmt.rd;
            end
            LI, ADDI: begin
                ctrl_d.load_imm  = (opcode == LI);
                ctrl_d.use_imm   = 1'b1;
                ctrl_d.reg_write = 1'b1;
                ctrl_d.rd        = instr.i_fmt.rd;
                ctrl_d.imm       = imm_i;
            end
            BEQ, BNE: begin
                ctrl_d.branch = (opcode == BEQ) ? BR_EQ : BR_NE;
                ctrl_d.imm    = imm_br;
            end
            JAL: begin
                ctrl_d.branch    = BR_JAL;
                ctrl_d.reg_write = 1'b1;
                ctrl_d.rd        = instr.i_fmt.rd;
                ctrl_d.imm       = imm_i;
            end
            OUT: begin
                // rd + 0 through the ALU
                ctrl_d.out_en  = 1'b1;
                ctrl_d.use_imm = 1'b1;
            end
            HALT: begin
                ctrl_d.halt = 1'b1;
            end
            default: begin
                ctrl_d = '0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            ctrl <= '0;
        end else if (decode_en) begin
            ctrl <= ctrl_d;
        end
    end

    always_ff @(posedge clk) begin
        if (decode_en) begin
            rs_a   <= (addr_a == '0) ? '0 : regs[addr_a];
            rs_b   <= (addr_b == '0) ? '0 : regs[addr_b];
            pc_out <= pc;
        end
        if (reg_wr.en) begin
            regs[reg_wr.rd] <= reg_wr.data;
        end
    end

endmodule

/* design/exec_alu.sv */
`timescale 1ns/100ps

module exec_alu
    import isa_pkg::*;
    import core_pkg::*;
(
    input  logic  clk,
    input  logic  reset_n,
    input  logic  exec_en,
    input  ctrl_t ctrl,
    input  word_t rs_a,
    input  word_t rs_b,
    output word_t result
);

    word_t op_b;
    word_t alu_out;

    assign op_b = ctrl.use_imm ? ctrl.imm : rs_b;

    always_comb begin
        case (ctrl.alu_op)
            ALU_ADD: alu_out = rs_a + op_b;
            ALU_SUB: alu_out = rs_a - op_b;
            ALU_AND: alu_out = rs_a & op_b;
            ALU_OR:  alu_out = rs_a | op_b;
            ALU_XOR: alu_out = rs_a ^ op_b;
            ALU_SLL: alu_out = rs_a << op_b[3:0];
            ALU_SRL: alu_out = rs_a >> op_b[3:0];
            ALU_SLT: alu_out = {15'd0, $signed(rs_a) < $signed(op_b)};
            default: alu_out = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            result <= '0;
        end else if (exec_en) begin
            // LI bypasses the ALU
            result <= ctrl.load_imm ? ctrl.imm : alu_out;
        end
    end

endmodule

/* design/branch_unit.sv */
`timescale 1ns/100ps

module branch_unit
    import isa_pkg::*;
    import core_pkg::*;
(
    input  logic  clk,
    input  logic  reset_n,
    input  logic  exec_en,
    input  ctrl_t ctrl,
    input  word_t rs_a,
    input  word_t rs_b,
    input  pc_t   pc,
    output logic  taken,
    output pc_t   target,
    output pc_t   link
);

    logic taken_d;

    always_comb begin
        case (ctrl.branch)
            BR_EQ:   taken_d = (rs_a == rs_b);
            BR_NE:   taken_d = (rs_a != rs_b);
            BR_JAL:  taken_d = 1'b1;
            default: taken_d = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            taken <= 1'b0;
        end else if (exec_en) begin
            taken <= taken_d;
        end
    end

    // Offset counts instructions
    always_ff @(posedge clk) begin
        if (exec_en) begin
            target <= pc + (ctrl.imm << 1);
            link   <= pc + INSTR_BYTES;
        end
    end

endmodule

/* design/retire_unit.sv */
`timescale 1ns/100ps

module retire_unit
    import isa_pkg::*;
    import core_pkg::*;
(
    input  logic       clk,
    input  logic       reset_n,
    input  logic       retire_en,
    input  ctrl_t      ctrl,
    input  word_t      result,
    input  logic       taken,
    input  pc_t        target,
    input  pc_t        link,
    input  logic       out_ready,
    output logic       out_valid,
    output logic [7:0] out_data,
    output reg_wr_t    reg_wr,
    output redirect_t  redirect,
    output logic       commit
);

    // Set once HALT retires, blocks any later output or commit
    logic halted;
    logic active;

    assign active = retire_en && !halted;

    assign out_valid = active && ctrl.out_en;
    assign out_data  = result[7:0];

    // OUT waits for the byte to transfer
    assign commit = active && (!ctrl.out_en || out_ready);

    assign reg_wr.en   = commit && ctrl.reg_write;
    assign reg_wr.rd   = ctrl.rd;
    assign reg_wr.data = (ctrl.branch == BR_JAL) ? link : result;

    assign redirect.next_pc = taken ? target : link;
    assign redirect.halt    = ctrl.halt;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            halted <= 1'b0;
        end else if (commit && ctrl.halt) begin
            halted <= 1'b1;
        end
    end

endmodule

/* design/cpu_top.sv */
`timescale 1ns/100ps

module cpu_top
    import isa_pkg::*;
    import core_pkg::*;
#(
    parameter int PROG_ADDR_BITS = 8
) (
    input  logic       clk,
    input  logic       reset_n,
    input  logic       load_valid,
    output logic       load_ready,
    input  load_t      load_data,
    output logic       out_valid,
    input  logic       out_ready,
    output logic [7:0] out_data,
    output logic       halted
);

    instr_u    instr;
    pc_t       fetch_pc;
    pc_t       dec_pc;
    logic      decode_en;
    logic      exec_en;
    logic      retire_en;
    ctrl_t     ctrl;
    word_t     rs_a;
    word_t     rs_b;
    word_t     alu_result;
    logic      br_taken;
    pc_t       br_target;
    pc_t       br_link;
    reg_wr_t   reg_wr;
    redirect_t redirect;
    logic      commit;

    fetch_unit #(
        .PROG_ADDR_BITS(PROG_ADDR_BITS)
    ) fetch0 (
        .clk       (clk),
        .reset_n   (reset_n),
        .load_valid(load_valid),
        .load_ready(load_ready),
        .load_data (load_data),
        .commit    (commit),
        .redirect  (redirect),
        .instr     (instr),
        .pc        (fetch_pc),
        .decode_en (decode_en),
        .exec_en   (exec_en),
        .retire_en (retire_en),
        .halted    (halted)
    );

    decode_stage decode0 (
        .clk      (clk),
        .reset_n  (reset_n),
        .decode_en(decode_en),
        .instr    (instr),
        .pc       (fetch_pc),
        .reg_wr   (reg_wr),
        .ctrl     (ctrl),
        .rs_a     (rs_a),
        .rs_b     (rs_b),
        .pc_out   (dec_pc)
    );

    exec_alu alu0 (
        .clk    (clk),
        .reset_n(reset_n),
        .exec_en(exec_en),
        .ctrl   (ctrl),
        .rs_a   (rs_a),
        .rs_b   (rs_b),
        .result (alu_result)
    );

    branch_unit branch0 (
        .clk    (clk),
        .reset_n(reset_n),
        .exec_en(exec_en),
        .ctrl   (ctrl),
        .rs_a   (rs_a),
        .rs_b   (rs_b),
        .pc     (dec_pc),
        .taken  (br_taken),
        .target (br_target),
        .link   (br_link)
    );

    retire_unit retire0 (
        .clk      (clk),
        .reset_n  (reset_n),
        .retire_en(retire_en),
        .ctrl     (ctrl),
        .result   (alu_result),
        .taken    (br_taken),
        .target   (br_target),
        .link     (br_link),
        .out_ready(out_ready),
        .out_valid(out_valid),
        .out_data (out_data),
        .reg_wr   (reg_wr),
        .redirect (redirect),
        .commit   (commit)
    );

endmodule

/* sim/cpu_props.sv */
`timescale 1ns/100ps

module cpu_props (
    input logic       clk,
    input logic       reset_n,
    input logic       out_valid,
    input logic       out_ready,
    input logic [7:0] out_data,
    input logic       halted
);

    int fail_count = 0;

    // A stalled byte stays offered and unchanged
    valid_held: assert property (@(posedge clk) disable iff (!reset_n)
        out_valid && !out_ready |=> out_valid)
        else begin
            $error("out_valid dropped before the byte was accepted");
            fail_count++;
        end

    data_stable: assert property (@(posedge clk) disable iff (!reset_n)
        out_valid && !out_ready |=> $stable(out_data))
        else begin
            $error("out_data changed while the byte was stalled");
            fail_count++;
        end

    halt_sticky: assert property (@(posedge clk) disable iff (!reset_n)
        halted |=> halted)
        else begin
            $error("halted fell after it was set");
            fail_count++;
        end

endmodule

/* sim/cpu_checker.sv */
`timescale 1ns/100ps

module cpu_checker #(
    parameter int MAX_EXP    = 64,
    parameter int NAME_BYTES = 16
) (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    load_ready,
    input  logic                    out_valid,
    input  logic                    out_ready,
    input  logic [7:0]              out_data,
    input  logic                    halted,
    input  logic [7:0]              exp_bytes [MAX_EXP],
    input  logic [8*NAME_BYTES-1:0] exp_names [MAX_EXP],
    input  int                      exp_count,
    input  int                      cycle_limit,
    input  int                      prop_fails,
    output logic                    done,
    output int                      error_total
);

    // Cycles to watch for stray bytes after halted rises
    localparam int HALT_WATCH = 20;

    int   cycles;
    int   out_idx;
    int   mismatches;
    int   other_errors;
    int   halt_cycles;
    logic running;

    function automatic string name_text(input logic [8*NAME_BYTES-1:0] packed_name);
        string text;
        text = "";
        for (int i = NAME_BYTES - 1; i >= 0; i--) begin
            if (packed_name[8*i +: 8] != 8'd0) begin
                text = $sformatf("%s%c", text, packed_name[8*i +: 8]);
            end
        end
        return text;
    endfunction

    task automatic check_byte();
        if (halted) begin
            other_errors++;
            $display("output byte %h arrived after halt", out_data);
        end else if (out_idx >= exp_count) begin
            other_errors++;
            $display("extra output byte %h beyond the %0d expected", out_data, exp_count);
        end else if (out_data !== exp_bytes[out_idx]) begin
            mismatches++;
            $display("mismatch in test %s: byte %0d expected %h, actual %h",
                     name_text(exp_names[out_idx]), out_idx, exp_bytes[out_idx], out_data);
        end
        out_idx++;
    endtask

    task automatic finish_run();
        if (halt_cycles < HALT_WATCH) begin
            other_errors++;
            $display("timeout: the CPU did not halt within %0d cycles", cycle_limit);
        end
        if (out_idx < exp_count) begin
            other_errors++;
            $display("missing output bytes: %0d of %0d arrived, first missing in test %s",
                     out_idx, exp_count, name_text(exp_names[out_idx]));
        end
        error_total = mismatches + other_errors + prop_fails;
        $display("checker summary: %0d mismatches, %0d other errors, %0d assertion failures",
                 mismatches, other_errors, prop_fails);
        done = 1'b1;
    endtask

    always @(posedge clk) begin
        if (!reset_n) begin
            done         = 1'b0;
            error_total  = 0;
            cycles       = 0;
            out_idx      = 0;
            mismatches   = 0;
            other_errors = 0;
            halt_cycles  = 0;
            running      = 1'b0;
        end else if (!done) begin
            cycles++;
            // Load port closes for good once the program starts
            if (!load_ready) begin
                running = 1'b1;
            end else if (running) begin
                other_errors++;
                $display("load_ready went high again after the program started");
            end
            if (out_valid && out_ready) begin
                check_byte();
            end
            if (halted) begin
                halt_cycles++;
            end
            if (halt_cycles >= HALT_WATCH || cycles >= cycle_limit) begin
                finish_run();
            end
        end
    end

endmodule

/* sim/tb_top.sv */
`timescale 1ns/100ps

module tb_top
    import isa_pkg::*;
();

    localparam int MAX_WORDS  = 256;
    localparam int MAX_EXP    = 64;
    localparam int NAME_BYTES = 16;

    logic        clk = 1'b0;
    logic        reset_n;
    logic        load_valid;
    logic        load_ready;
    logic [24:0] load_data;
    logic        out_valid;
    logic        out_ready = 1'b0;
    logic [7:0]  out_data;
    logic        halted;

    logic [7:0]              prog_addr [MAX_WORDS];
    word_t                   prog_word [MAX_WORDS];
    int                      prog_count;
    logic [7:0]              exp_bytes [MAX_EXP];
    logic [8*NAME_BYTES-1:0] exp_names [MAX_EXP];
    int                      exp_count;
    int                      instr_count;
    int                      cycle_limit;
    logic [31:0]             lcg_state = 32'h108;
    logic                    file_ok;
    logic                    check_done;
    int                      error_total;

    cpu_top #(
        .PROG_ADDR_BITS(8)
    ) dut0 (
        .clk       (clk),
        .reset_n   (reset_n),
        .load_valid(load_valid),
        .load_ready(load_ready),
        .load_data (load_data),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data),
        .halted    (halted)
    );

    cpu_checker #(
        .MAX_EXP   (MAX_EXP),
        .NAME_BYTES(NAME_BYTES)
    ) checker0 (
        .clk        (clk),
        .reset_n    (reset_n),
        .load_ready (load_ready),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_data   (out_data),
        .halted     (halted),
        .exp_bytes  (exp_bytes),
        .exp_names  (exp_names),
        .exp_count  (exp_count),
        .cycle_limit(cycle_limit),
        .prop_fails (dut0.retire0.props0.fail_count),
        .done       (check_done),
        .error_total(error_total)
    );

    bind retire_unit cpu_props props0 (
        .clk      (clk),
        .reset_n  (reset_n),
        .out_valid(out_valid),
        .out_ready(out_ready),
        .out_data (out_data),
        .halted   (halted)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    // Holds the output stream off on roughly one cycle in four
    always @(negedge clk) begin
        if (reset_n) begin
            lcg_state = lcg_next(lcg_state);
            out_ready = (lcg_state[17:16] != 2'd0);
        end
    end

    task automatic read_program(output logic ok);
        int                      fd;
        int                      code;
        logic [8*NAME_BYTES-1:0] tag;
        logic [8*NAME_BYTES-1:0] test_name;
        logic [8*128-1:0]        rest;
        logic [7:0]              addr;
        word_t                   word;
        logic [7:0]              value;
        fd = $fopen("sim/program_input.txt", "r");
        ok = (fd != 0);
        test_name = '0;
        if (ok) begin
            while ($fscanf(fd, "%s", tag) == 1) begin
                if (tag[7:0] == "#") begin
                    code = $fgets(rest, fd);
                end else if (tag[7:0] == "P") begin
                    code = $fscanf(fd, "%h %h", addr, word);
                    prog_addr[prog_count] = addr;
                    prog_word[prog_count] = word;
                    prog_count++;
                end else if (tag[7:0] == "T") begin
                    code = $fscanf(fd, "%s", test_name);
                end else if (tag[7:0] == "E") begin
                    code = $fscanf(fd, "%h", value);
                    exp_bytes[exp_count] = value;
                    exp_names[exp_count] = test_name;
                    exp_count++;
                end else if (tag[7:0] == "N") begin
                    code = $fscanf(fd, "%d", instr_count);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic stream_word(input logic [7:0] addr, input word_t word, input logic last);
        @(negedge clk);
        load_valid = 1'b1;
        load_data  = {addr, word, last};
        // Ready seen here means the word moves on the next rising edge
        while (!load_ready) begin
            @(negedge clk);
        end
    endtask

    initial begin
        reset_n     = 1'b0;
        load_valid  = 1'b0;
        load_data   = '0;
        prog_count  = 0;
        exp_count   = 0;
        instr_count = 0;
        cycle_limit = 0;
        read_program(file_ok);
        if (!file_ok) begin
            $display("could not open sim/program_input.txt");
            $display("ERRORS FOUND");
            $finish;
        end else begin
            cycle_limit = 16 * instr_count + prog_count + 100;
            repeat (10) @(posedge clk);
            @(negedge clk);
            reset_n = 1'b1;
            for (int i = 0; i < prog_count; i++) begin
                stream_word(prog_addr[i], prog_word[i], i == prog_count - 1);
            end
            @(negedge clk);
            load_valid = 1'b0;
        end
    end

    initial begin
        @(posedge check_done);
        if (error_total == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* sim/program_input.txt */
# P <word address> <instruction>, T <test name>, E <expected output byte>
# N <executed instruction count, decimal>, all other values hex
T alu
P 00 812D
P 01 82F3
P 02 0312
P 03 D300
P 04 1312
P 05 D300
P 06 2312
P 07 D300
P 08 3312
P 09 D300
P 0A 4312
P 0B D300
P 0C 5312
P 0D D300
P 0E 6312
P 0F D300
P 10 7312
P 11 D300
E 20
E 3A
E 21
E FF
E DE
E 68
E 05
E 00
T branch
P 12 852D
P 13 A513
P 14 86E1
P 15 D600
P 16 8611
P 17 D600
P 18 A523
P 19 8622
P 1A D600
P 1B B523
P 1C 86E3
P 1D D600
P 1E 8633
P 1F D600
P 20 B513
P 21 8644
P 22 D600
P 23 8703
P 24 97FF
P 25 D700
P 26 B70E
E 11
E 22
E 33
E 44
E 02
E 01
E 00
T jal
P 27 C803
P 28 86E5
P 29 D600
P 2A D800
P 2B E000
P 2C D600
E 50
N 44

/* build.f */
design/isa_pkg.sv
design/core_pkg.sv
design/fetch_unit.sv
design/decode_stage.sv
design/exec_alu.sv
design/branch_unit.sv
design/retire_unit.sv
design/cpu_top.sv
sim/cpu_props.sv
sim/cpu_checker.sv
sim/tb_top.sv

/* Makefile */
SIM = obj_dir/Vtb_top

compile:
	verilator --binary --assert -f build.f --top-module tb_top -Mdir obj_dir

run: compile
	-$(SIM) +verilator+error+limit+100 > sim.log 2>&1
	cat sim.log
	grep -q "^NO ERRORS$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: compile run clean
